//--- Makefile
# Verilator build and run of the register table testbench

TOP = reg_table_tb
LOG = sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass message
sim:
	verilator --binary --timing --assert -f reg_table.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/reg_table_sva.sv
/*
 * Structural checks on the scoreboard storage.
 * Bound into reg_table_store from the testbench.
 */

`include "reg_table_config.svh"

`timescale 1ns/1ps
`default_nettype none

module reg_table_sva (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  reg_table_pkg::rt_entry_t [`RT_NUM_TAGS-1:0]  entries_i,
    input  logic [`RT_NUM_TAGS-1:0]                      entry_valid_i,
    input  logic                                         space_available_i,
    input  logic                                         all_dst_written_i
);

    import reg_table_pkg::*;

    // Overlap between any two valid entries
    logic dup_dst;
    logic dup_tag;

    always_comb begin
        dup_dst = 1'b0;
        dup_tag = 1'b0;
        for (int i = 0; i < `RT_NUM_TAGS; i++) begin
            for (int j = i + 1; j < `RT_NUM_TAGS; j++) begin
                dup_dst |= entry_valid_i[i] && entry_valid_i[j]
                           && (entries_i[i].dst == entries_i[j].dst)
                           && (entries_i[i].subwarp_id == entries_i[j].subwarp_id);
                dup_tag |= entry_valid_i[i] && entry_valid_i[j]
                           && (entries_i[i].producer == entries_i[j].producer);
            end
        end
    end

    // ######################################
    // Table invariants
    // ######################################

    a_unique_dst: assert property (@(posedge clk_i) disable iff (!arst_n_i) !dup_dst)
        else $error("Two valid entries hold the same destination and subwarp");

    a_unique_tag: assert property (@(posedge clk_i) disable iff (!arst_n_i) !dup_tag)
        else $error("Two valid entries hold the same producer tag");

    a_space_flag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        space_available_i |-> !(&entry_valid_i))
        else $error("Space flag high while every entry is valid");

    a_written_flag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        all_dst_written_i |-> !(|entry_valid_i))
        else $error("All-written flag high while an entry is valid");

endmodule

`default_nettype wire

//--- dv/reg_table_tb.sv
/*
 * Testbench of the register table: directed phases, then a seeded random mix
 * checked every cycle against a reference model, then a drain of all tags.
 */

`include "reg_table_config.svh"

`timescale 1ns/1ps
`default_nettype none

module reg_table_tb;

    import reg_table_pkg::*;

    localparam int CLK_HALF        = 5;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 500;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + `RT_NUM_TAGS + 200;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    insert_i;
    rt_insert_t              insert_req_i;
    operand_regs_t           operands_reg_i;
    rt_eu_resp_t             eu_resp_i;
    logic                    space_available_o;
    logic                    all_dst_written_o;
    logic [`RT_OPERANDS-1:0] operands_ready_o;
    operand_tags_t           operands_tag_o;

    // Reference model of the table
    rt_entry_t [`RT_NUM_TAGS-1:0] m_entries;
    logic [`RT_NUM_TAGS-1:0]      m_valid;
    string                        test_name;
    int                           cycle_count;
    tag_t                         new_tag;

    reg_table u_reg_table (.*);

    bind reg_table_store reg_table_sva u_sva (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .entries_i         (entries_o),
        .entry_valid_i     (entry_valid_o),
        .space_available_i (space_available_o),
        .all_dst_written_i (all_dst_written_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    // Hang guard
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "Timeout");
        end
    end

    // ######################################
    // Helpers
    // ######################################

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("test failed");
            $fatal(1, "Mismatch");
        end
    endtask

    function automatic logic tag_held(input tag_t t);
        logic held;
        held = 1'b0;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            held |= m_valid[e] && (m_entries[e].producer == t);
        end
        return held;
    endfunction

    // Random tag that is held, or absent, in the model
    function automatic tag_t pick_tag(input logic want_held);
        int   start;
        tag_t t;
        start = $urandom_range(`RT_NUM_TAGS - 1, 0);
        for (int k = 0; k < `RT_NUM_TAGS; k++) begin
            t = tag_t'((start + k) % `RT_NUM_TAGS);
            if (tag_held(t) == want_held) begin
                return t;
            end
        end
        return tag_t'(start);
    endfunction

    task automatic set_insert(input logic en, input int sw, input int dst, input tag_t tag);
        insert_i     = en;
        insert_req_i = '{tag: tag, subwarp_id: subwarp_id_t'(sw), dst: reg_idx_t'(dst)};
    endtask

    task automatic set_eu(input logic valid, input tag_t tag);
        eu_resp_i = '{valid: valid, tag: tag};
    endtask

    // Wait until inputs settle, then compare flags and lookups with the model
    task automatic settle_and_check();
        logic found;
        tag_t exp_tag;
        logic exp_rdy;
        #(CLK_HALF - 1);
        check_value("space_available_o", 32'(!(&m_valid)), 32'(space_available_o));
        check_value("all_dst_written_o", 32'(!(|m_valid)), 32'(all_dst_written_o));
        for (int op = 0; op < `RT_OPERANDS; op++) begin
            found   = 1'b0;
            exp_tag = '0;
            for (int e = 0; e < `RT_NUM_TAGS; e++) begin
                if (!found && m_valid[e] && (m_entries[e].dst == operands_reg_i[op])
                    && (m_entries[e].subwarp_id == insert_req_i.subwarp_id)) begin
                    found   = 1'b1;
                    exp_tag = m_entries[e].producer;
                end
            end
            // Producer on the bus this cycle bypasses the wait
            exp_rdy = !found || (eu_resp_i.valid && (eu_resp_i.tag == exp_tag));
            check_value("operands_ready_o", 32'(exp_rdy), 32'(operands_ready_o[op]));
            check_value("operands_tag_o", 32'(exp_tag), 32'(operands_tag_o[op]));
        end
    endtask

    // Model update across the edge, back at the falling edge
    task automatic advance();
        rt_entry_t [`RT_NUM_TAGS-1:0] n_entries;
        logic [`RT_NUM_TAGS-1:0]      n_valid;
        int                           slot;
        n_entries = m_entries;
        n_valid   = m_valid;
        slot      = -1;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            if (eu_resp_i.valid && m_valid[e] && (m_entries[e].producer == eu_resp_i.tag)) begin
                n_valid[e] = 1'b0;
            end
        end
        // Full table drops the insert
        if (insert_i && !(&m_valid)) begin
            for (int e = 0; e < `RT_NUM_TAGS; e++) begin
                if (slot < 0 && m_valid[e] && (m_entries[e].dst == insert_req_i.dst)
                    && (m_entries[e].subwarp_id == insert_req_i.subwarp_id)) begin
                    slot = e;
                end
            end
            if (slot >= 0) begin
                n_entries[slot].producer = insert_req_i.tag;
            end else begin
                for (int e = 0; e < `RT_NUM_TAGS; e++) begin
                    if (slot < 0 && !m_valid[e]) begin
                        slot = e;
                    end
                end
                n_entries[slot] = '{subwarp_id: insert_req_i.subwarp_id,
                                    dst: insert_req_i.dst, producer: insert_req_i.tag};
            end
            n_valid[slot] = 1'b1;
        end
        @(posedge clk_i);
        m_entries = n_entries;
        m_valid   = n_valid;
        @(negedge clk_i);
    endtask

    task automatic cycle();
        settle_and_check();
        advance();
    endtask

    // ######################################
    // Stimulus
    // ######################################

    initial begin
        void'($urandom(87));
        clk_i          = 1'b0;
        arst_n_i       = 1'b0;
        cycle_count    = 0;
        m_entries      = '0;
        m_valid        = '0;
        operands_reg_i = '0;
        set_insert(1'b0, 0, 0, '0);
        set_eu(1'b0, '0);
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // Empty table, every register reads ready
        test_name = "reset";
        for (int r = 0; r < (1 << `RT_REG_IDX_WIDTH); r++) begin
            operands_reg_i = {`RT_OPERANDS{reg_idx_t'(r)}};
            settle_and_check();
            check_value("operands_ready_o", 32'({`RT_OPERANDS{1'b1}}), 32'(operands_ready_o));
            advance();
        end

        // Distinct destinations until full
        test_name = "fill";
        for (int i = 0; i < `RT_NUM_TAGS; i++) begin
            set_insert(1'b1, 0, i, tag_t'(i));
            cycle();
        end
        // Would retag dst 0 if it got through
        set_insert(1'b1, 0, 0, tag_t'(1));
        settle_and_check();
        check_value("space_available_o", 32'd0, 32'(space_available_o));
        advance();
        set_insert(1'b0, 0, 0, '0);
        operands_reg_i = '0;
        cycle();

        // Free the last slot, then move dst 1 to a new tag
        test_name = "reuse";
        set_eu(1'b1, tag_t'(`RT_NUM_TAGS - 1));
        set_insert(1'b0, 0, 0, '0);
        cycle();
        set_eu(1'b0, '0);
        set_insert(1'b1, 0, 1, tag_t'(`RT_NUM_TAGS - 1));
        cycle();
        set_insert(1'b0, 0, 1, '0);
        operands_reg_i = {`RT_OPERANDS{reg_idx_t'(1)}};
        settle_and_check();
        check_value("operands_tag_o[0]", 32'(`RT_NUM_TAGS - 1), 32'(operands_tag_o[0]));
        check_value("space_available_o", 32'd1, 32'(space_available_o));
        advance();

        // Writeback bypass, then the cleared entry
        test_name = "writeback";
        set_eu(1'b1, tag_t'(`RT_NUM_TAGS - 1));
        settle_and_check();
        check_value("operands_ready_o[0]", 32'd1, 32'(operands_ready_o[0]));
        check_value("operands_tag_o[0]", 32'(`RT_NUM_TAGS - 1), 32'(operands_tag_o[0]));
        advance();
        set_eu(1'b0, '0);
        cycle();

        // Same register in the other subwarp
        test_name = "subwarp";
        operands_reg_i = '0;
        set_insert(1'b0, 1, 0, '0);
        cycle();
        new_tag = pick_tag(1'b0);
        set_insert(1'b1, 1, 0, new_tag);
        cycle();
        set_insert(1'b0, 1, 0, '0);
        settle_and_check();
        check_value("operands_tag_o[0]", 32'(new_tag), 32'(operands_tag_o[0]));
        advance();

        // Random traffic, inserts use only tags absent from the model
        test_name = "random";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            set_insert($urandom_range(99, 0) < 50, $urandom_range(`RT_WARP_WIDTH - 1, 0),
                       $urandom_range((1 << `RT_REG_IDX_WIDTH) - 1, 0), pick_tag(1'b0));
            if ($urandom_range(99, 0) < 40) begin
                set_eu(1'b1, pick_tag($urandom_range(99, 0) < 85));
            end else begin
                set_eu(1'b0, '0);
            end
            operands_reg_i = operand_regs_t'($urandom);
            cycle();
        end

        // Return every held tag
        test_name = "drain";
        set_insert(1'b0, 0, 0, '0);
        while (!all_dst_written_o) begin
            set_eu(1'b1, pick_tag(1'b1));
            cycle();
        end
        set_eu(1'b0, '0);
        settle_and_check();
        check_value("space_available_o", 32'd1, 32'(space_available_o));

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/operand_dep_check.sv
/*
 * Combinational dependency lookup for the operands of the decoded instruction.
 * Same-cycle writeback bypass marks an operand ready as its producer returns.
 */

`include "reg_table_config.svh"

`timescale 1ns/1ps
`default_nettype none

module operand_dep_check (
    // Lookup key, shared by all operands
    input  reg_table_pkg::subwarp_id_t                   subwarp_id_i,
    input  reg_table_pkg::operand_regs_t                 operands_reg_i,

    // Table state from the storage
    input  reg_table_pkg::rt_entry_t [`RT_NUM_TAGS-1:0]  entries_i,
    input  logic [`RT_NUM_TAGS-1:0]                      entry_valid_i,

    // Writeback seen this cycle
    input  reg_table_pkg::rt_eu_resp_t                   eu_resp_i,

    // Toward the wait buffer
    output logic [`RT_OPERANDS-1:0]                      operands_ready_o,
    output reg_table_pkg::operand_tags_t                 operands_tag_o
);

    import reg_table_pkg::*;

    // ######################################
    // Signals
    // ######################################

    // Entry hits, one row per operand
    logic [`RT_OPERANDS-1:0][`RT_NUM_TAGS-1:0] op_match;
    // Operand waits on some entry
    logic [`RT_OPERANDS-1:0]                   op_found;
    // Producer of the winning entry
    operand_tags_t                             op_tag;
    // Producer returns this cycle
    logic [`RT_OPERANDS-1:0]                   op_bypass;

    // ######################################
    // Entry compare
    // ######################################

    for (genvar op = 0; op < `RT_OPERANDS; op++) begin : gen_op
        for (genvar e = 0; e < `RT_NUM_TAGS; e++) begin : gen_entry
            // Register and subwarp both have to match
            assign op_match[op][e] = entry_valid_i[e]
                                     && (entries_i[e].dst == operands_reg_i[op])
                                     && (entries_i[e].subwarp_id == subwarp_id_i);
        end
    end

    // ######################################
    // Priority select
    // ######################################

    always_comb begin
        for (int op = 0; op < `RT_OPERANDS; op++) begin
            op_found[op] = |op_match[op];
            // No hit reads tag zero
            op_tag[op]   = '0;
            // Walk downward so the lowest hit is written last
            for (int e = `RT_NUM_TAGS - 1; e >= 0; e--) begin
                if (op_match[op][e]) begin
                    op_tag[op] = entries_i[e].producer;
                end
            end
        end
    end

    // ######################################
    // Writeback bypass
    // ######################################

    always_comb begin
        for (int op = 0; op < `RT_OPERANDS; op++) begin
            op_bypass[op] = eu_resp_i.valid && (eu_resp_i.tag == op_tag[op]);
        end
    end

    // Ready when nothing pending or the producer is on the bus now
    assign operands_ready_o = ~op_found | op_bypass;

    // Tag still names the producer during a bypass
    assign operands_tag_o = op_tag;

endmodule

`default_nettype wire

//--- hdl/reg_table.sv
/*
 * Scoreboard top of the issue stage, tracking the producer tag of each destination.
 * Decoder inserts, the execution unit retires, operand lookups answer in the same cycle.
 */

`include "reg_table_config.svh"

`timescale 1ns/1ps
`default_nettype none

module reg_table (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    // Decoder side
    input  logic                           insert_i,
    input  reg_table_pkg::rt_insert_t      insert_req_i,
    input  reg_table_pkg::operand_regs_t   operands_reg_i,
    output logic                           space_available_o,

    // Execution unit writeback
    input  reg_table_pkg::rt_eu_resp_t     eu_resp_i,

    // Fetcher side, no pending destination
    output logic                           all_dst_written_o,

    // Wait buffer side
    output logic [`RT_OPERANDS-1:0]        operands_ready_o,
    output reg_table_pkg::operand_tags_t   operands_tag_o
);

    import reg_table_pkg::*;

    // ######################################
    // Storage to lookup
    // ######################################

    rt_entry_t [`RT_NUM_TAGS-1:0] entries;
    logic [`RT_NUM_TAGS-1:0]      entry_valid;

    // ######################################
    // Storage
    // ######################################

    // Updates land one edge after the request
    reg_table_store u_store (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .insert_i          (insert_i),
        .insert_req_i      (insert_req_i),
        .eu_resp_i         (eu_resp_i),
        .entries_o         (entries),
        .entry_valid_o     (entry_valid),
        .space_available_o (space_available_o),
        .all_dst_written_o (all_dst_written_o)
    );

    // ######################################
    // Operand lookup
    // ######################################

    // Operands belong to the subwarp of the request
    operand_dep_check u_dep_check (
        .subwarp_id_i     (insert_req_i.subwarp_id),
        .operands_reg_i   (operands_reg_i),
        .entries_i        (entries),
        .entry_valid_i    (entry_valid),
        .eu_resp_i        (eu_resp_i),
        .operands_ready_o (operands_ready_o),
        .operands_tag_o   (operands_tag_o)
    );

endmodule

`default_nettype wire

//--- hdl/reg_table_config.svh
/*
 * Sizing macros for the register table scoreboard.
 * Include wherever table depth, warp width or operand count is needed.
 */

`ifndef REG_TABLE_CONFIG_SVH
`define REG_TABLE_CONFIG_SVH

// ######################################
// Table geometry
// ######################################

// Entries in the table, one per in-flight tag
`define RT_NUM_TAGS 4

// Subwarps tracked separately
`define RT_WARP_WIDTH 2

// ######################################
// Instruction format
// ######################################

// Bits of an architectural register index
`define RT_REG_IDX_WIDTH 2

// Source operands looked up per decoded instruction
`define RT_OPERANDS 2

`endif

//--- hdl/reg_table_pkg.sv
/*
 * Shared types of the register table: tags, register indices, entries and requests.
 * Modules import it inside their body and use scoped names in their port lists.
 */

`include "reg_table_config.svh"

`default_nettype none

package reg_table_pkg;

    // ######################################
    // Field widths
    // ######################################

    // Tag bits follow table depth
    localparam int unsigned TAG_WIDTH        = $clog2(`RT_NUM_TAGS);
    // Single subwarp still needs one id bit
    localparam int unsigned SUBWARP_ID_WIDTH =
        (`RT_WARP_WIDTH > 1) ? $clog2(`RT_WARP_WIDTH) : 1;

    // ######################################
    // Scalar types
    // ######################################

    typedef logic [TAG_WIDTH-1:0]          tag_t;
    typedef logic [`RT_REG_IDX_WIDTH-1:0]  reg_idx_t;
    typedef logic [SUBWARP_ID_WIDTH-1:0]   subwarp_id_t;

    // ######################################
    // Bundles
    // ######################################

    // One scoreboard slot
    typedef struct packed {
        subwarp_id_t subwarp_id;
        reg_idx_t    dst;
        tag_t        producer;
    } rt_entry_t;

    // Decoder insert request
    typedef struct packed {
        tag_t        tag;
        subwarp_id_t subwarp_id;
        reg_idx_t    dst;
    } rt_insert_t;

    // Execution unit writeback, no back-pressure
    typedef struct packed {
        logic valid;
        tag_t tag;
    } rt_eu_resp_t;

    // Per-operand vectors
    typedef reg_idx_t [`RT_OPERANDS-1:0] operand_regs_t;
    typedef tag_t     [`RT_OPERANDS-1:0] operand_tags_t;

endpackage

`default_nettype wire

//--- hdl/reg_table_store.sv
/*
 * Entry storage of the scoreboard with clear, reuse and allocate update rules.
 * Exports its state to the operand check and drives the space and all-written flags.
 */

`include "reg_table_config.svh"

`timescale 1ns/1ps
`default_nettype none

module reg_table_store (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,

    // Decoder insert, gated here by the full flag
    input  logic                                         insert_i,
    input  reg_table_pkg::rt_insert_t                    insert_req_i,

    // Writeback from the execution unit
    input  reg_table_pkg::rt_eu_resp_t                   eu_resp_i,

    // State toward the operand check
    output reg_table_pkg::rt_entry_t [`RT_NUM_TAGS-1:0]  entries_o,
    output logic [`RT_NUM_TAGS-1:0]                      entry_valid_o,

    // Status flags
    output logic                                         space_available_o,
    output logic                                         all_dst_written_o
);

    import reg_table_pkg::*;

    // ######################################
    // Signals
    // ######################################

    // Registered table
    rt_entry_t [`RT_NUM_TAGS-1:0] entries_q;
    rt_entry_t [`RT_NUM_TAGS-1:0] entries_d;
    logic [`RT_NUM_TAGS-1:0]      valid_q;
    logic [`RT_NUM_TAGS-1:0]      valid_d;

    // Per-entry match vectors on pre-edge state
    logic [`RT_NUM_TAGS-1:0]      clear_match;
    logic [`RT_NUM_TAGS-1:0]      reuse_match;
    logic [`RT_NUM_TAGS-1:0]      reuse_sel;
    logic [`RT_NUM_TAGS-1:0]      free_sel;

    logic                         reuse_hit;
    logic                         insert_en;

    // Keep only the lowest set bit
    function automatic logic [`RT_NUM_TAGS-1:0] lowest_set(
        input logic [`RT_NUM_TAGS-1:0] vec
    );
        logic [`RT_NUM_TAGS-1:0] sel;
        logic                    seen;
        sel  = '0;
        seen = 1'b0;
        for (int i = 0; i < `RT_NUM_TAGS; i++) begin
            if (vec[i] && !seen) begin
                sel[i] = 1'b1;
                seen   = 1'b1;
            end
        end
        return sel;
    endfunction

    // ######################################
    // Status flags
    // ######################################

    // Full only when every slot holds a destination
    assign space_available_o = ~(&valid_q);
    // Nothing pending
    assign all_dst_written_o = ~(|valid_q);

    // Only accepted inserts touch the table
    assign insert_en = insert_i & space_available_o;

    // ######################################
    // Match logic
    // ######################################

    always_comb begin
        for (int i = 0; i < `RT_NUM_TAGS; i++) begin
            // Writeback retires every slot of that producer
            clear_match[i] = eu_resp_i.valid && valid_q[i]
                             && (entries_q[i].producer == eu_resp_i.tag);
            // Same destination in the same subwarp
            reuse_match[i] = valid_q[i]
                             && (entries_q[i].dst == insert_req_i.dst)
                             && (entries_q[i].subwarp_id == insert_req_i.subwarp_id);
        end
    end

    assign reuse_hit = |reuse_match;
    assign reuse_sel = lowest_set(reuse_match);
    // Lowest free slot before the edge
    assign free_sel  = lowest_set(~valid_q);

    // ######################################
    // Next state
    // ######################################

    always_comb begin
        entries_d = entries_q;
        // Clear first, insert below may revive a slot
        valid_d   = valid_q & ~clear_match;

        if (insert_en) begin
            for (int i = 0; i < `RT_NUM_TAGS; i++) begin
                if (reuse_hit) begin
                    // Reuse wins over a same-edge clear
                    if (reuse_sel[i]) begin
                        valid_d[i]            = 1'b1;
                        entries_d[i].producer = insert_req_i.tag;
                    end
                end else if (free_sel[i]) begin
                    valid_d[i]   = 1'b1;
                    entries_d[i] = '{subwarp_id: insert_req_i.subwarp_id,
                                     dst:        insert_req_i.dst,
                                     producer:   insert_req_i.tag};
                end
            end
        end
    end

    // ######################################
    // Registers
    // ######################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= '0;
            entries_q <= '0;
        end else begin
            valid_q   <= valid_d;
            entries_q <= entries_d;
        end
    end

    // Read side sees registered state only
    assign entries_o     = entries_q;
    assign entry_valid_o = valid_q;

endmodule

`default_nettype wire

//--- reg_table.f
+incdir+hdl
hdl/reg_table_pkg.sv
hdl/reg_table_store.sv
hdl/operand_dep_check.sv
hdl/reg_table.sv
dv/reg_table_sva.sv
dv/reg_table_tb.sv
